/* project.f */
+incdir+source
source/ex_pkg.sv
source/alu.sv
source/mult.sv
source/ex_stage.sv
sim/tb_clk_gen.sv
sim/ex_stage_asserts.sv
sim/ex_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert \
  --top-module ex_stage_tb \
  -f project.f \
  -o ex_stage_sim \
  && ./obj_dir/ex_stage_sim > "$LOG" 2>&1 \
  || echo "Build or simulation ended with an error"

grep -q "Simulation PASSED" "$LOG" 2>/dev/null \
  && echo "Result: pass" && exit 0 \
  || { echo "Result: fail, see $LOG"; exit 1; }

/* sim/ex_stage_asserts.sv */
//////////////////////////////
// Concurrent assertions on the execute stage
// Bound to ex_stage from the testbench
//////////////////////////////

`include "ex_params.svh"

module ex_stage_asserts
(
  input  logic             clk,
  input  logic             rst_n,
  input  ex_pkg::ex_req_t  req_i,
  input  logic             stall_wb_i,
  input  ex_pkg::ex_fw_t   fw_o,
  input  ex_pkg::ex_wb_t   wb_o
);

  // Number of failed assertions, read by the testbench
  int fail_count = 0;

  // EX/WB register keeps its packet while write-back stalls
  stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    stall_wb_i |=> $stable(wb_o))
  else
  begin
    fail_count++;
    $error("wb_o changed during a stall");
  end

  // First edge after reset still sees the cleared register
  reset_value_a: assert property (@(posedge clk)
    $rose(rst_n) |-> (wb_o.we == 1'b0) && (wb_o == '0))
  else
  begin
    fail_count++;
    $error("wb_o not cleared after reset");
  end

  // CSR data wins over multiplier and ALU
  csr_priority_a: assert property (@(posedge clk) disable iff (!rst_n)
    req_i.csr_access |-> (fw_o.wdata == req_i.csr_rdata))
  else
  begin
    fail_count++;
    $error("CSR data not forwarded");
  end

  // Plain product, same low half whatever mult_sign says
  mult_low_half_a: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i.mult_en && !req_i.mac_en && !req_i.csr_access) |->
    (fw_o.wdata == req_i.operand_a * req_i.operand_b))
  else
  begin
    fail_count++;
    $error("multiplier low half depends on signedness");
  end

endmodule

/* sim/ex_stage_tb.sv */
//////////////////////////////
// Testbench of the execute stage
// Random instructions each cycle, checked against a model of the forwarding,
// address, branch and EX/WB rules
//////////////////////////////

`include "ex_params.svh"

module ex_stage_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int SHAMT_W      = $clog2(`EX_XLEN);
  localparam int N_ALU        = 400;
  localparam int N_MUL        = 300;
  localparam int N_PRIO       = 200;
  localparam int N_ADDR       = 200;
  localparam int N_STALL      = 300;
  localparam int TOTAL_CYCLES = RESET_CYCLES + N_ALU + N_MUL + N_PRIO + N_ADDR + N_STALL;
  // Fifty spare cycles on top of the test length
  localparam int WATCHDOG_TIME = (TOTAL_CYCLES + 50) * CLK_PERIOD;

  // Which fields the generator is free to randomize
  typedef enum int {
    MODE_ALU,
    MODE_MUL,
    MODE_PRIO,
    MODE_ANY
  } test_mode_e;

  logic                 clk;
  logic                 rst_n;
  ex_pkg::ex_req_t      req;
  logic                 stall_wb;
  ex_pkg::ex_fw_t       fw;
  ex_pkg::ex_wb_t       wb;
  logic [`EX_XLEN-1:0]  data_addr;
  logic [`EX_XLEN-1:0]  jump_target;
  logic                 branch_decision;

  // Model state of the EX/WB register
  ex_pkg::ex_wb_t       exp_wb;
  int                   errors;
  int                   checks;
  int                   assert_errors;

  tb_clk_gen clk_gen_inst
  (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  ex_stage ex_stage_inst
  (
    .clk               ( clk             ),
    .rst_n             ( rst_n           ),
    .req_i             ( req             ),
    .stall_wb_i        ( stall_wb        ),
    .fw_o              ( fw              ),
    .wb_o              ( wb              ),
    .data_addr_o       ( data_addr       ),
    .jump_target_o     ( jump_target     ),
    .branch_decision_o ( branch_decision )
  );

  bind ex_stage ex_stage_asserts ex_stage_asserts_inst
  (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .req_i      ( req_i      ),
    .stall_wb_i ( stall_wb_i ),
    .fw_o       ( fw_o       ),
    .wb_o       ( wb_o       )
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [`EX_XLEN-1:0] alu_model(input ex_pkg::alu_op_e op,
                                                    input logic [`EX_XLEN-1:0] a,
                                                    input logic [`EX_XLEN-1:0] b);
    logic flag;
    flag = 1'b0;
    case (op)
      ex_pkg::ADD:  return a + b;
      ex_pkg::SUB:  return a - b;
      ex_pkg::AND:  return a & b;
      ex_pkg::OR:   return a | b;
      ex_pkg::XOR:  return a ^ b;
      ex_pkg::SLL:  return a << b[SHAMT_W-1:0];
      ex_pkg::SRL:  return a >> b[SHAMT_W-1:0];
      ex_pkg::SRA:  return $signed(a) >>> b[SHAMT_W-1:0];
      ex_pkg::EQ:   flag = (a == b);
      ex_pkg::NE:   flag = (a != b);
      ex_pkg::SLT, ex_pkg::LT:   flag = ($signed(a) < $signed(b));
      ex_pkg::GE:   flag = ($signed(a) >= $signed(b));
      ex_pkg::SLTU, ex_pkg::LTU: flag = (a < b);
      ex_pkg::GEU:  flag = (a >= b);
      default:      flag = 1'b0;
    endcase
    // Compares land in bit 0
    return {{(`EX_XLEN-1){1'b0}}, flag};
  endfunction

  function automatic logic [`EX_XLEN-1:0] mult_model(input ex_pkg::ex_req_t q);
    logic [2*`EX_XLEN-1:0] full;
    full = {{`EX_XLEN{1'b0}}, q.operand_a} * {{`EX_XLEN{1'b0}}, q.operand_b};
    return full[`EX_XLEN-1:0] + (q.mac_en ? q.operand_c : '0);
  endfunction

  // CSR first, then multiplier, then ALU
  function automatic ex_pkg::ex_fw_t fw_model(input ex_pkg::ex_req_t q);
    ex_pkg::ex_fw_t f;
    f.we    = q.alu_we;
    f.waddr = q.alu_waddr;
    if (q.csr_access)
      f.wdata = q.csr_rdata;
    else if (q.mult_en)
      f.wdata = mult_model(q);
    else
      f.wdata = alu_model(q.alu_op, q.operand_a, q.operand_b);
    return f;
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  function automatic ex_pkg::ex_req_t random_req(input test_mode_e mode);
    logic [31:0]     r;
    ex_pkg::ex_req_t q;
    r = $urandom();
    q.alu_op          = ex_pkg::alu_op_e'(r[3:0]);
    q.mult_sign       = ex_pkg::mult_sign_e'(r[4]);
    q.mac_en          = r[5];
    q.mult_en         = r[6];
    q.csr_access      = r[7];
    q.alu_we          = r[8];
    q.prepost_useincr = r[9];
    q.wb_we           = r[10];
    q.alu_waddr       = r[15:11];
    q.wb_waddr        = r[20:16];
    q.operand_a       = $urandom();
    q.operand_b       = $urandom();
    q.operand_c       = $urandom();
    q.csr_rdata       = $urandom();
    q.rb_data         = $urandom();
    // Top of the range, so the address adder carries out
    if (r[22:21] == 2'b00)
    begin
      q.operand_a = q.operand_a | 32'hfff0_0000;
      q.operand_b = q.operand_b | 32'hfff0_0000;
    end
    // Equal operands now and then for EQ, GE and GEU
    if (r[24:23] == 2'b00)
      q.operand_b = q.operand_a;
    case (mode)
      MODE_ALU:
      begin
        q.mult_en    = 1'b0;
        q.csr_access = 1'b0;
      end
      MODE_MUL:
      begin
        q.mult_en    = 1'b1;
        q.csr_access = 1'b0;
      end
      default:
      begin
      end
    endcase
    return q;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_fw(input ex_pkg::ex_fw_t got, input ex_pkg::ex_fw_t exp,
                          input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_wb(input ex_pkg::ex_wb_t got, input ex_pkg::ex_wb_t exp,
                          input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input logic [`EX_XLEN-1:0] got,
                            input logic [`EX_XLEN-1:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    logic [`EX_XLEN-1:0] alu_exp;
    logic [`EX_XLEN-1:0] addr_exp;
    alu_exp  = alu_model(req.alu_op, req.operand_a, req.operand_b);
    addr_exp = req.prepost_useincr ? req.operand_a + req.operand_b : req.operand_a;
    check_fw(fw, fw_model(req), "forwarding packet");
    check_word(data_addr, addr_exp, "load/store address");
    check_word(jump_target, req.operand_c, "jump target");
    check_word({{(`EX_XLEN-1){1'b0}}, branch_decision},
               {{(`EX_XLEN-1){1'b0}}, alu_exp[0]}, "branch decision");
    check_wb(wb, exp_wb, "write-back packet");
  endtask

  // New request on each rising edge, checks on the falling edge
  task automatic run_test(input test_mode_e mode, input int n, input string name);
    int              errors_before;
    logic [31:0]     r;
    ex_pkg::ex_req_t next_req;
    errors_before = errors;
    repeat (n)
    begin
      @(posedge clk);
      // EX/WB capture on the same edge as the DUT
      if (!stall_wb)
      begin
        exp_wb.we      = req.wb_we;
        exp_wb.waddr   = req.wb_waddr;
        exp_wb.rb_data = req.rb_data;
      end
      next_req = random_req(mode);
      r        = $urandom();
      req      <= next_req;
      // Stall on about a quarter of the cycles
      stall_wb <= (r[1:0] == 2'b00);
      @(negedge clk);
      check_outputs();
    end
    $display("%s: %0d cycles, %0d errors", name, n, errors - errors_before);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    errors   = 0;
    checks   = 0;
    req      = '0;
    stall_wb = 1'b0;
    exp_wb   = '0;
    void'($urandom(32'h1af3));

    wait (rst_n === 1'b1);
    check_wb(wb, exp_wb, "write-back packet after reset");
    $display("reset values: %0d errors", errors);

    run_test(MODE_ALU, N_ALU, "alu operations");
    run_test(MODE_MUL, N_MUL, "multiply and mac");
    run_test(MODE_PRIO, N_PRIO, "result priority");
    run_test(MODE_ANY, N_ADDR, "load/store address");
    run_test(MODE_ANY, N_STALL, "write-back stall");

    assert_errors = ex_stage_inst.ex_stage_asserts_inst.fail_count;
    $display("Checks %0d, errors %0d, assertion failures %0d",
             checks, errors, assert_errors);
    if (errors == 0 && assert_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // Ends a run that stops making progress
  initial
  begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired before all tests finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* sim/tb_clk_gen.sv */
//////////////////////////////
// Clock and reset source of the testbench
// 20-unit clock, active-low reset held for 8 cycles
//////////////////////////////

module tb_clk_gen
(
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the capture edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* source/alu.sv */
//////////////////////////////
// Combinational ALU of the execute stage
// Arithmetic, logic, shifts and compares, plus a separate load/store address adder
//////////////////////////////

`include "ex_params.svh"

module alu
(
  input  ex_pkg::alu_op_e      operator_i,
  input  logic [`EX_XLEN-1:0]  operand_a_i,
  input  logic [`EX_XLEN-1:0]  operand_b_i,

  output logic [`EX_XLEN-1:0]  result_o,
  // To the load/store unit
  output logic [`EX_XLEN-1:0]  adder_lsu_o
);

  // Shift amount comes from the low bits of operand B
  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic                  adder_sub;
  logic [`EX_XLEN-1:0]   adder_op_b;
  logic [`EX_XLEN:0]     adder_full;
  logic [`EX_XLEN-1:0]   adder_result;
  logic                  adder_carry;

  logic                  is_equal;
  logic                  is_less_u;
  logic                  is_less_s;
  logic                  cmp_result;

  logic [SHAMT_W-1:0]    shamt;
  logic                  shift_fill;
  logic [`EX_XLEN:0]     shift_right_in;
  logic [`EX_XLEN:0]     shift_right_full;
  logic [`EX_XLEN-1:0]   shift_left;

  //////////////////////////////
  // Main adder
  //////////////////////////////

  // Everything but ADD needs A - B
  assign adder_sub  = (operator_i != ex_pkg::ADD);
  assign adder_op_b = adder_sub ? ~operand_b_i : operand_b_i;

  // Two's complement subtract as A + ~B + 1, carry kept in the top bit
  assign adder_full = {1'b0, operand_a_i} + {1'b0, adder_op_b}
                    + {{`EX_XLEN{1'b0}}, adder_sub};

  assign adder_result = adder_full[`EX_XLEN-1:0];
  assign adder_carry  = adder_full[`EX_XLEN];

  //////////////////////////////
  // Comparisons
  //////////////////////////////

  // Zero difference means equal operands
  assign is_equal  = (adder_result == '0);
  // No carry out of A - B means a borrow, so A < B unsigned
  assign is_less_u = ~adder_carry;
  // Differing signs decide directly, else the sign of the difference
  assign is_less_s = (operand_a_i[`EX_XLEN-1] != operand_b_i[`EX_XLEN-1]) ?
                     operand_a_i[`EX_XLEN-1] : adder_result[`EX_XLEN-1];

  always_comb
  begin
    case (operator_i)
      ex_pkg::EQ:             cmp_result = is_equal;
      ex_pkg::NE:             cmp_result = ~is_equal;
      ex_pkg::SLT, ex_pkg::LT: cmp_result = is_less_s;
      ex_pkg::GE:             cmp_result = ~is_less_s;
      ex_pkg::SLTU, ex_pkg::LTU: cmp_result = is_less_u;
      ex_pkg::GEU:            cmp_result = ~is_less_u;
      default:                cmp_result = 1'b0;
    endcase
  end

  //////////////////////////////
  // Shifter
  //////////////////////////////

  assign shamt = operand_b_i[SHAMT_W-1:0];

  // Extra top bit carries the sign for SRA, zero for SRL
  assign shift_fill       = (operator_i == ex_pkg::SRA) & operand_a_i[`EX_XLEN-1];
  assign shift_right_in   = {shift_fill, operand_a_i};
  assign shift_right_full = $signed(shift_right_in) >>> shamt;

  assign shift_left = operand_a_i << shamt;

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb
  begin
    case (operator_i)
      ex_pkg::ADD, ex_pkg::SUB: result_o = adder_result;
      ex_pkg::AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::SLL:  result_o = shift_left;
      ex_pkg::SRL, ex_pkg::SRA: result_o = shift_right_full[`EX_XLEN-1:0];
      // Set-less-than and branch compares
      default:      result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result};
    endcase
  end

  // Own adder for the address, off the critical path of the main adder
  assign adder_lsu_o = operand_a_i + operand_b_i;

endmodule

/* source/ex_params.svh */
//////////////////////////////
// Width parameters of the execute stage
// Include this in every file that sizes data, register addresses or opcodes
//////////////////////////////

`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

//////////////////////////////
// Data path
//////////////////////////////

// Width of operands and results
`define EX_XLEN 32

// Register file address width, 32 registers
`define EX_RADDR_W 5

// Width of the ALU opcode field
`define EX_ALU_OP_W 4

`endif

/* source/ex_pkg.sv */
//////////////////////////////
// Shared types of the execute stage
// Opcodes, signedness and the packets exchanged with decode, fetch and write-back
//////////////////////////////

`include "ex_params.svh"

package ex_pkg;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // ALU opcodes
  // EQ through GEU and the set-less-than codes return 0 or 1 in bit 0
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    SLL  = 4'h5,
    SRL  = 4'h6,
    SRA  = 4'h7,
    SLT  = 4'h8,
    SLTU = 4'h9,
    EQ   = 4'hA,
    NE   = 4'hB,
    LT   = 4'hC,
    GE   = 4'hD,
    LTU  = 4'hE,
    GEU  = 4'hF
  } alu_op_e;

  // Operand signedness of the multiplier
  typedef enum logic {
    UU = 1'b0,
    SS = 1'b1
  } mult_sign_e;

  //////////////////////////////
  // Packets
  //////////////////////////////

  // One decoded instruction from decode
  typedef struct packed {
    alu_op_e                 alu_op;
    logic [`EX_XLEN-1:0]     operand_a;
    logic [`EX_XLEN-1:0]     operand_b;
    // MAC addend, also the jump target
    logic [`EX_XLEN-1:0]     operand_c;
    logic                    mult_en;
    logic                    mac_en;
    mult_sign_e              mult_sign;
    logic                    csr_access;
    logic [`EX_XLEN-1:0]     csr_rdata;
    logic                    alu_we;
    logic [`EX_RADDR_W-1:0]  alu_waddr;
    logic                    prepost_useincr;
    // Passed straight on to write-back
    logic                    wb_we;
    logic [`EX_RADDR_W-1:0]  wb_waddr;
    logic [`EX_XLEN-1:0]     rb_data;
  } ex_req_t;

  // Forwarding packet back to decode
  typedef struct packed {
    logic                    we;
    logic [`EX_RADDR_W-1:0]  waddr;
    logic [`EX_XLEN-1:0]     wdata;
  } ex_fw_t;

  // Content of the EX/WB register
  typedef struct packed {
    logic                    we;
    logic [`EX_RADDR_W-1:0]  waddr;
    logic [`EX_XLEN-1:0]     rb_data;
  } ex_wb_t;

endpackage

/* source/ex_stage.sv */
//////////////////////////////
// Execute stage of the in-order core
// Hosts the ALU and multiplier, forwards results to decode and holds the EX/WB register
//////////////////////////////

`include "ex_params.svh"

module ex_stage
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Decoded instruction from decode
  input  ex_pkg::ex_req_t      req_i,
  // Write-back back-pressure
  input  logic                 stall_wb_i,

  // Forwarding to decode
  output ex_pkg::ex_fw_t       fw_o,
  // Registered write-back packet
  output ex_pkg::ex_wb_t       wb_o,

  // To the load/store unit
  output logic [`EX_XLEN-1:0]  data_addr_o,

  // To fetch
  output logic [`EX_XLEN-1:0]  jump_target_o,
  output logic                 branch_decision_o
);

  logic [`EX_XLEN-1:0]  alu_result;
  logic [`EX_XLEN-1:0]  alu_adder_lsu;
  logic [`EX_XLEN-1:0]  mult_result;
  ex_pkg::ex_wb_t       wb_next;

  //////////////////////////////
  // ALU
  //////////////////////////////

  alu alu_inst
  (
    .operator_i  ( req_i.alu_op    ),
    .operand_a_i ( req_i.operand_a ),
    .operand_b_i ( req_i.operand_b ),
    .result_o    ( alu_result      ),
    .adder_lsu_o ( alu_adder_lsu   )
  );

  //////////////////////////////
  // Multiplier
  //////////////////////////////

  // Operand C doubles as the accumulate value
  mult mult_inst
  (
    .signed_mode_i ( req_i.mult_sign ),
    .mac_en_i      ( req_i.mac_en    ),
    .op_a_i        ( req_i.operand_a ),
    .op_b_i        ( req_i.operand_b ),
    .mac_i         ( req_i.operand_c ),
    .result_o      ( mult_result     )
  );

  //////////////////////////////
  // Forwarding
  //////////////////////////////

  // Write enable and address follow decode unchanged
  // Data priority is CSR, then multiplier, then ALU
  always_comb
  begin
    fw_o.we    = req_i.alu_we;
    fw_o.waddr = req_i.alu_waddr;
    fw_o.wdata = alu_result;

    if (req_i.mult_en)
      fw_o.wdata = mult_result;

    if (req_i.csr_access)
      fw_o.wdata = req_i.csr_rdata;
  end

  // Post-increment uses the base alone, otherwise base plus offset
  assign data_addr_o = req_i.prepost_useincr ? alu_adder_lsu : req_i.operand_a;

  // Branch taken when the compare result is 1
  assign branch_decision_o = alu_result[0];
  assign jump_target_o     = req_i.operand_c;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_comb
  begin
    wb_next.we      = req_i.wb_we;
    wb_next.waddr   = req_i.wb_waddr;
    wb_next.rb_data = req_i.rb_data;
  end

  // Holds its content for as long as write-back stalls
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_o <= '0;
    end
    else if (!stall_wb_i)
    begin
      wb_o <= wb_next;
    end
  end

endmodule

/* source/mult.sv */
//////////////////////////////
// Single-cycle 32x32 multiplier
// Returns the low product half, optionally plus an accumulate operand
//////////////////////////////

`include "ex_params.svh"

module mult
(
  input  ex_pkg::mult_sign_e   signed_mode_i,
  input  logic                 mac_en_i,

  input  logic [`EX_XLEN-1:0]  op_a_i,
  input  logic [`EX_XLEN-1:0]  op_b_i,
  // Accumulate operand
  input  logic [`EX_XLEN-1:0]  mac_i,

  output logic [`EX_XLEN-1:0]  result_o
);

  logic                         ext_bit_a;
  logic                         ext_bit_b;
  logic signed [`EX_XLEN:0]     op_a_ext;
  logic signed [`EX_XLEN:0]     op_b_ext;
  logic signed [2*`EX_XLEN+1:0] product;
  logic [`EX_XLEN-1:0]          product_lo;
  logic [`EX_XLEN-1:0]          mac_addend;

  //////////////////////////////
  // Operand extension
  //////////////////////////////

  // Sign bit for SS, zero for UU
  assign ext_bit_a = (signed_mode_i == ex_pkg::SS) & op_a_i[`EX_XLEN-1];
  assign ext_bit_b = (signed_mode_i == ex_pkg::SS) & op_b_i[`EX_XLEN-1];

  // 33-bit signed view covers both modes with one multiplier
  assign op_a_ext = $signed({ext_bit_a, op_a_i});
  assign op_b_ext = $signed({ext_bit_b, op_b_i});

  //////////////////////////////
  // Product and accumulate
  //////////////////////////////

  // Full width product, high half reserved for a later mulh path
  assign product = op_a_ext * op_b_ext;

  // Low half is independent of the signedness
  assign product_lo = product[`EX_XLEN-1:0];

  assign mac_addend = mac_en_i ? mac_i : '0;

  // Wraps modulo 2^32 like the plain product
  assign result_o = product_lo + mac_addend;

endmodule
